// ==== hdl/icache_pkg.sv ====
// cache size localparams, field positions, vector typedefs, fetch state enum
`default_nettype none

package icache_pkg;

	localparam int ADDR_W      = 32;
	localparam int WORD_W      = 32;
	localparam int NUM_WAYS    = 4;
	localparam int NUM_SETS    = 16;
	localparam int LINE_WORDS  = 8;
	localparam int GROUP_WORDS = 2;   // words returned per hit

	localparam int OFFSET_W    = 2;   // byte in word
	localparam int WORD_IDX_W  = 3;   // word in line
	localparam int INDEX_W     = 4;
	localparam int TAG_W       = 23;
	localparam int WAY_W       = 2;
	localparam int GROUP_SEL_W = WORD_IDX_W - 1;   // top bits of word index

	localparam int INDEX_LSB   = OFFSET_W + WORD_IDX_W;   // set index at 8..5
	localparam int TAG_LSB     = INDEX_LSB + INDEX_W;     // tag at 31..9

	typedef logic [ADDR_W-1:0]             addr_t;
	typedef logic [WORD_W-1:0]             word_t;
	typedef logic [GROUP_WORDS*WORD_W-1:0] group_t;   // low word at low address
	typedef logic [TAG_W-1:0]              tag_t;
	typedef logic [INDEX_W-1:0]            index_t;
	typedef logic [WORD_IDX_W-1:0]         word_idx_t;
	typedef logic [WAY_W-1:0]              way_t;
	typedef logic [NUM_WAYS-1:0]           hit_vec_t;
	typedef logic [2:0]                    plru_t;    // tree bits, root in bit 0

	typedef enum logic [1:0] {IDLE, LOOKUP, REFILL} fetch_state_t;

endpackage

`default_nettype wire

// ==== hdl/icache_tag_store.sv ====
// tag and valid arrays, per-way hit compare, tree pseudo-LRU and victim select
`timescale 1ns/1ps
`default_nettype none

module icache_tag_store
	import icache_pkg::*;
(
	input  logic     clk,
	input  logic     i_rst_n,
	input  index_t   i_index,
	input  tag_t     i_tag,
	input  logic     i_access,       // hit seen this cycle
	input  way_t     i_access_way,
	input  logic     i_fill_done,    // last refill word written
	input  way_t     i_fill_way,
	output hit_vec_t o_hit,
	output way_t     o_victim
);

	tag_t     tag_mem [NUM_WAYS][NUM_SETS];
	logic     valid   [NUM_WAYS][NUM_SETS];
	plru_t    plru    [NUM_SETS];
	plru_t    plru_cur;   // tree bits of the looked-up set
	plru_t    plru_upd;
	hit_vec_t inv_vec;    // ways still empty in this set
	way_t     upd_way;
	logic     upd_en;

	// compare all ways at once
	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			o_hit[w]   = valid[w][i_index] && (tag_mem[w][i_index] == i_tag);
			inv_vec[w] = !valid[w][i_index];
		end
	end

	assign plru_cur = plru[i_index];

	// empty way wins, lowest number first
	always_comb begin
		if (plru_cur[0])
			o_victim = {1'b1, plru_cur[2]};   // ways 2/3
		else
			o_victim = {1'b0, plru_cur[1]};   // ways 0/1
		for (int w = NUM_WAYS - 1; w >= 0; w--) begin
			if (inv_vec[w])
				o_victim = way_t'(w);
		end
	end

	// fill and hit never share a cycle, fill checked first anyway
	assign upd_en  = i_fill_done | i_access;
	assign upd_way = i_fill_done ? i_fill_way : i_access_way;

	always_comb begin
		plru_upd    = plru_cur;
		plru_upd[0] = ~upd_way[1];   // root points away from used pair
		if (upd_way[1])
			plru_upd[2] = ~upd_way[0];   // point at partner
		else
			plru_upd[1] = ~upd_way[0];
	end

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int s = 0; s < NUM_SETS; s++) begin
				plru[s] <= '0;
				for (int w = 0; w < NUM_WAYS; w++)
					valid[w][s] <= 1'b0;
			end
		end else begin
			if (i_fill_done)
				valid[i_fill_way][i_index] <= 1'b1;
			if (upd_en)
				plru[i_index] <= plru_upd;
		end
	end

	// new tag lands with the last word
	always_ff @(posedge clk) begin
		if (i_fill_done)
			tag_mem[i_fill_way][i_index] <= i_tag;
	end

	// refill only follows a miss, so one line per tag and set
	a_hit_onehot: assert property (@(posedge clk) disable iff (!i_rst_n) $onehot0(o_hit))
		else $error("tag store: more than one way hit");

endmodule

`default_nettype wire

// ==== hdl/icache_data_store.sv ====
// per-way line storage, word writes on refill, fetch group read of every way
`timescale 1ns/1ps
`default_nettype none

module icache_data_store
	import icache_pkg::*;
(
	input  logic                   clk,
	input  index_t                 i_index,
	input  logic [GROUP_SEL_W-1:0] i_group_sel,
	input  logic                   i_fill_we,
	input  way_t                   i_fill_way,
	input  word_idx_t              i_fill_word,
	input  word_t                  i_fill_data,
	output group_t                 o_group_0,
	output group_t                 o_group_1,
	output group_t                 o_group_2,
	output group_t                 o_group_3
);

	word_t  line_mem [NUM_WAYS][NUM_SETS][LINE_WORDS];
	group_t rd_group [NUM_WAYS];   // selected group per way

	// one bus word per strobe
	always_ff @(posedge clk) begin
		if (i_fill_we)
			line_mem[i_fill_way][i_index][i_fill_word] <= i_fill_data;
	end

	// same set in all ways, words in ascending order
	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			for (int g = 0; g < GROUP_WORDS; g++) begin
				rd_group[w][g*WORD_W +: WORD_W] =
					line_mem[w][i_index][word_idx_t'(i_group_sel * GROUP_WORDS + g)];
			end
		end
	end

	assign o_group_0 = rd_group[0];
	assign o_group_1 = rd_group[1];
	assign o_group_2 = rd_group[2];
	assign o_group_3 = rd_group[3];

	// bus must deliver real data with each strobe
	a_fill_known: assert property (@(posedge clk) i_fill_we |-> !$isunknown(i_fill_data))
		else $error("data store: unknown refill data");

endmodule

`default_nettype wire

// ==== hdl/icache_fetch_ctrl.sv ====
// request latch, lookup/refill FSM, bus request, refill word count, hit data select
`timescale 1ns/1ps
`default_nettype none

module icache_fetch_ctrl
	import icache_pkg::*;
(
	input  logic                   clk,
	input  logic                   i_rst_n,
	input  logic                   i_req,
	input  addr_t                  i_addr,
	input  hit_vec_t               i_hit,
	input  way_t                   i_victim,
	input  group_t                 i_group_0,
	input  group_t                 i_group_1,
	input  group_t                 i_group_2,
	input  group_t                 i_group_3,
	input  logic                   i_bus_valid,
	input  word_t                  i_bus_data,
	output index_t                 o_index,
	output tag_t                   o_tag,
	output logic [GROUP_SEL_W-1:0] o_group_sel,
	output logic                   o_access,
	output way_t                   o_access_way,
	output logic                   o_fill_we,
	output way_t                   o_fill_way,
	output word_idx_t              o_fill_word,
	output word_t                  o_fill_data,
	output logic                   o_fill_done,
	output logic                   o_ready,
	output logic                   o_data_valid,
	output group_t                 o_data,
	output logic                   o_bus_req,
	output addr_t                  o_bus_addr
);

	fetch_state_t state;
	addr_t        req_addr;   // held for the whole miss
	word_idx_t    word_cnt;   // next refill word
	way_t         fill_way;
	way_t         hit_way;
	group_t       hit_group;
	logic         hit_any;
	logic         fill_last;

	// address fields to both stores
	assign o_index     = req_addr[TAG_LSB-1:INDEX_LSB];
	assign o_tag       = req_addr[ADDR_W-1:TAG_LSB];
	assign o_group_sel = req_addr[INDEX_LSB-1 -: GROUP_SEL_W];

	assign hit_any = |i_hit;

	// one-hot to way number
	always_comb begin
		hit_way = '0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (i_hit[w])
				hit_way = way_t'(w);
		end
	end

	always_comb begin
		case (hit_way)
			2'd0:    hit_group = i_group_0;
			2'd1:    hit_group = i_group_1;
			2'd2:    hit_group = i_group_2;
			default: hit_group = i_group_3;
		endcase
	end

	assign o_access     = (state == LOOKUP) && hit_any;   // plru touch
	assign o_access_way = hit_way;
	assign o_fill_we    = (state == REFILL) && i_bus_valid;
	assign o_fill_way   = fill_way;
	assign o_fill_word  = word_cnt;
	assign o_fill_data  = i_bus_data;
	assign fill_last    = (word_cnt == word_idx_t'(LINE_WORDS - 1));
	assign o_fill_done  = o_fill_we && fill_last;
	assign o_ready      = (state == IDLE);

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state        <= IDLE;
			o_data_valid <= 1'b0;
			o_bus_req    <= 1'b0;
			word_cnt     <= '0;
		end else begin
			o_data_valid <= 1'b0;   // strobes last one cycle
			o_bus_req    <= 1'b0;
			case (state)
				IDLE: begin
					if (i_req)
						state <= LOOKUP;
				end
				LOOKUP: begin
					if (hit_any) begin
						state        <= IDLE;
						o_data_valid <= 1'b1;
					end else begin
						state     <= REFILL;
						o_bus_req <= 1'b1;
						word_cnt  <= '0;
					end
				end
				REFILL: begin
					if (o_fill_we) begin
						word_cnt <= word_cnt + 1'b1;
						if (fill_last)
							state <= LOOKUP;   // look again, now hits
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && i_req)
			req_addr <= i_addr;
		if (state == LOOKUP) begin
			if (hit_any) begin
				o_data <= hit_group;
			end else begin
				fill_way   <= i_victim;
				o_bus_addr <= {req_addr[ADDR_W-1:INDEX_LSB], {INDEX_LSB{1'b0}}};   // line base
			end
		end
	end

	// requester has no stall, must wait for o_ready
	a_req_idle: assert property (@(posedge clk) disable iff (!i_rst_n) i_req |-> state == IDLE)
		else $error("fetch ctrl: request while busy");
	a_bus_refill: assert property (@(posedge clk) disable iff (!i_rst_n)
		i_bus_valid |-> state == REFILL)
		else $error("fetch ctrl: bus data outside refill");

endmodule

`default_nettype wire

// ==== hdl/icache_top.sv ====
// cache top, tag store and data store side by side under the fetch controller
`timescale 1ns/1ps
`default_nettype none

module icache_top
	import icache_pkg::*;
(
	input  logic   clk,
	input  logic   i_rst_n,
	input  logic   i_req,
	input  addr_t  i_addr,
	input  logic   i_bus_valid,
	input  word_t  i_bus_data,
	output logic   o_ready,
	output logic   o_data_valid,
	output group_t o_data,
	output logic   o_bus_req,
	output addr_t  o_bus_addr
);

	index_t                 lk_index;   // latched lookup set
	tag_t                   lk_tag;
	logic [GROUP_SEL_W-1:0] lk_group_sel;
	hit_vec_t               hit;
	way_t                   victim;
	group_t                 group_0;
	group_t                 group_1;
	group_t                 group_2;
	group_t                 group_3;
	logic                   access;
	way_t                   access_way;
	logic                   fill_we;
	way_t                   fill_way;
	word_idx_t              fill_word;
	word_t                  fill_data;
	logic                   fill_done;

	icache_tag_store u_tag_store (
		.clk          (clk),
		.i_rst_n      (i_rst_n),
		.i_index      (lk_index),
		.i_tag        (lk_tag),
		.i_access     (access),
		.i_access_way (access_way),
		.i_fill_done  (fill_done),
		.i_fill_way   (fill_way),
		.o_hit        (hit),
		.o_victim     (victim)
	);

	icache_data_store u_data_store (
		.clk         (clk),
		.i_index     (lk_index),
		.i_group_sel (lk_group_sel),
		.i_fill_we   (fill_we),
		.i_fill_way  (fill_way),
		.i_fill_word (fill_word),
		.i_fill_data (fill_data),
		.o_group_0   (group_0),
		.o_group_1   (group_1),
		.o_group_2   (group_2),
		.o_group_3   (group_3)
	);

	icache_fetch_ctrl u_fetch_ctrl (
		.clk          (clk),
		.i_rst_n      (i_rst_n),
		.i_req        (i_req),
		.i_addr       (i_addr),
		.i_hit        (hit),
		.i_victim     (victim),
		.i_group_0    (group_0),
		.i_group_1    (group_1),
		.i_group_2    (group_2),
		.i_group_3    (group_3),
		.i_bus_valid  (i_bus_valid),
		.i_bus_data   (i_bus_data),
		.o_index      (lk_index),
		.o_tag        (lk_tag),
		.o_group_sel  (lk_group_sel),
		.o_access     (access),
		.o_access_way (access_way),
		.o_fill_we    (fill_we),
		.o_fill_way   (fill_way),
		.o_fill_word  (fill_word),
		.o_fill_data  (fill_data),
		.o_fill_done  (fill_done),
		.o_ready      (o_ready),
		.o_data_valid (o_data_valid),
		.o_data       (o_data),
		.o_bus_req    (o_bus_req),
		.o_bus_addr   (o_bus_addr)
	);

endmodule

`default_nettype wire

// ==== tb/tb_clock_gen.sv ====
// testbench clock, 20 ns period, and power-on reset held for two cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clk,
	output logic o_rst_n
);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;   // 20 ns period
	end

	initial begin
		o_rst_n = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);   // release on a falling edge
		o_rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// ==== tb/icache_checker.sv ====
// response checker: data against memory rule, bus request count and address, hit latency, ready
`timescale 1ns/1ps
`default_nettype none

module icache_checker
	import icache_pkg::*;
(
	input  logic   clk,
	input  logic   i_rst_n,
	input  logic   i_req,
	input  addr_t  i_addr,
	input  logic   i_exp_miss,   // row expects a refill
	input  int     i_row,
	input  logic   i_ready,
	input  logic   i_data_valid,
	input  group_t i_data,
	input  logic   i_bus_req,
	input  addr_t  i_bus_addr,
	output int     o_ok_cnt,
	output int     o_bad_cnt
);

	localparam int WAIT_LIMIT = 400;   // cycles, well above a slow refill

	// word at byte address a
	function automatic word_t mem_word(input addr_t a);
		return {a[15:0], ~a[15:0]};
	endfunction

	initial begin
		addr_t  addr;
		addr_t  base;
		addr_t  bus_addr;
		group_t exp_data;
		logic   exp_miss;
		logic   ready_bad;   // o_ready out of step with the response
		logic   ready_got;
		logic   ready_exp;
		int     row;
		int     cycles;
		int     bus_cnt;
		bit     bad;
		o_ok_cnt  = 0;
		o_bad_cnt = 0;
		forever begin
			@(posedge clk);   // inputs settled since the falling edge
			if (i_rst_n && i_req) begin
				addr      = i_addr;
				exp_miss  = i_exp_miss;
				row       = i_row;
				base      = {addr[31:3], 3'b000};   // group base
				exp_data  = {mem_word(base + 32'd4), mem_word(base)};
				cycles    = 0;
				bus_cnt   = 0;
				bus_addr  = '0;
				bad       = 1'b0;
				ready_bad = 1'b0;
				ready_got = 1'b0;
				ready_exp = 1'b0;
				// DUT outputs are registers, stable at the falling edge
				do begin
					@(negedge clk);
					cycles++;
					if (i_bus_req) begin
						bus_cnt++;
						bus_addr = i_bus_addr;
					end
					if (!ready_bad && i_ready !== i_data_valid) begin   // busy until response
						ready_bad = 1'b1;
						ready_got = i_ready;
						ready_exp = i_data_valid;
					end
				end while (!i_data_valid && cycles < WAIT_LIMIT);
				if (!i_data_valid) begin
					$display("row %0d: no response from the cache within %0d cycles",
						row, WAIT_LIMIT);
					bad = 1'b1;
				end else begin
					if (i_data !== exp_data) begin
						$display("Fail row %0d o_data: got %h expected %h", row, i_data, exp_data);
						bad = 1'b1;
					end
					if (bus_cnt != (exp_miss ? 1 : 0)) begin
						$display("Fail row %0d o_bus_req count: got %h expected %h",
							row, bus_cnt, exp_miss ? 1 : 0);
						bad = 1'b1;
					end
					if (exp_miss && bus_cnt == 1 && bus_addr !== {addr[31:5], 5'b0}) begin
						$display("Fail row %0d o_bus_addr: got %h expected %h",
							row, bus_addr, {addr[31:5], 5'b0});
						bad = 1'b1;
					end
					if (!exp_miss && cycles != 2) begin   // hit is fixed at two cycles
						$display("Fail row %0d o_data_valid latency: got %h expected %h",
							row, cycles, 2);
						bad = 1'b1;
					end
					if (ready_bad) begin
						$display("Fail row %0d o_ready: got %h expected %h",
							row, ready_got, ready_exp);
						bad = 1'b1;
					end
				end
				$display("row %0d addr %h miss %0d: %s", row, addr, exp_miss, bad ? "bad" : "ok");
				if (bad)
					o_bad_cnt++;
				else
					o_ok_cnt++;
			end
		end
	end

endmodule

`default_nettype wire

// ==== tb/icache_tb.sv ====
// testbench top: stimulus table, replacement model, bus memory responder, DUT, report
`timescale 1ns/1ps
`default_nettype none

module icache_tb
	import icache_pkg::*;
();

	localparam int          FIXED_N     = 14;
	localparam int          RAND_N      = 24;
	localparam int          NROWS       = FIXED_N + RAND_N;
	localparam int          READY_LIMIT = 500;   // longer than the checker's wait
	localparam int unsigned SEED        = 32'h13a8;

	// columns: reset before row, miss expected, request address
	localparam logic [33:0] FIXED_TAB [FIXED_N] = '{
		{1'b0, 1'b1, 32'h0000_1040},   // cold miss
		{1'b0, 1'b0, 32'h0000_1040},   // same address hits
		{1'b0, 1'b0, 32'h0000_1048},   // other groups of the line
		{1'b0, 1'b0, 32'h0000_1054},
		{1'b0, 1'b0, 32'h0000_105c},
		{1'b0, 1'b1, 32'h0000_20a0},   // set 5, ways 0..3
		{1'b0, 1'b1, 32'h0000_22a0},
		{1'b0, 1'b1, 32'h0000_24a0},
		{1'b0, 1'b1, 32'h0000_26a0},
		{1'b0, 1'b1, 32'h0000_28a0},   // evicts 20a0
		{1'b0, 1'b0, 32'h0000_22a4},
		{1'b0, 1'b1, 32'h0000_20a8},
		{1'b0, 1'b0, 32'h0000_1044},   // still cached
		{1'b1, 1'b1, 32'h0000_1040}    // after reset, misses again
	};

	logic        clk;
	logic        gen_rst_n;
	logic        mid_rst_n;   // second reset in mid-run
	logic        rst_n;
	logic        req;
	addr_t       addr;
	logic        bus_valid;
	word_t       bus_data;
	logic        ready;
	logic        data_valid;
	group_t      data;
	logic        bus_req;
	addr_t       bus_addr;
	logic        exp_miss;
	int          row;
	int          ok_cnt;
	int          bad_cnt;
	logic [33:0] tab       [NROWS];
	bit          tab_model [NROWS];   // expectation comes from the model
	tag_t        m_tag     [NUM_SETS][NUM_WAYS];
	bit          m_valid   [NUM_SETS][NUM_WAYS];
	plru_t       m_plru    [NUM_SETS];

	assign rst_n = gen_rst_n & mid_rst_n;

	tb_clock_gen u_clock_gen (.clk(clk), .o_rst_n(gen_rst_n));

	icache_top icache_top_i (
		.clk          (clk),
		.i_rst_n      (rst_n),
		.i_req        (req),
		.i_addr       (addr),
		.i_bus_valid  (bus_valid),
		.i_bus_data   (bus_data),
		.o_ready      (ready),
		.o_data_valid (data_valid),
		.o_data       (data),
		.o_bus_req    (bus_req),
		.o_bus_addr   (bus_addr)
	);

	icache_checker u_checker (
		.clk          (clk),
		.i_rst_n      (rst_n),
		.i_req        (req),
		.i_addr       (addr),
		.i_exp_miss   (exp_miss),
		.i_row        (row),
		.i_ready      (ready),
		.i_data_valid (data_valid),
		.i_data       (data),
		.i_bus_req    (bus_req),
		.i_bus_addr   (bus_addr),
		.o_ok_cnt     (ok_cnt),
		.o_bad_cnt    (bad_cnt)
	);

	function automatic word_t mem_word(input addr_t a);
		return {a[15:0], ~a[15:0]};   // address in upper half, inverse below
	endfunction

	// fixed rows first, then random rows in sets 0/1 with six tags
	task automatic build_table();
		int unsigned tag_sel;
		int unsigned set_sel;
		int unsigned word_sel;
		for (int r = 0; r < NROWS; r++) begin
			if (r < FIXED_N) begin
				tab[r]       = FIXED_TAB[r];
				tab_model[r] = 1'b0;
			end else begin
				tag_sel      = $urandom_range(5, 0);
				set_sel      = $urandom_range(1, 0);
				word_sel     = $urandom_range(7, 0);
				tab[r]       = {2'b00, 32'h0001_0000 | (tag_sel << 9) | (set_sel << 5) |
					(word_sel << 2)};
				tab_model[r] = 1'b1;
			end
		end
	endtask

	task automatic model_clear();
		for (int s = 0; s < NUM_SETS; s++) begin
			m_plru[s] = '0;
			for (int w = 0; w < NUM_WAYS; w++)
				m_valid[s][w] = 1'b0;
		end
	endtask

	// lookup, fill on miss, then tree update for the used way
	task automatic model_access(input addr_t a, output bit miss);
		index_t idx;
		tag_t   tg;
		way_t   way;
		bit     found;
		idx  = a[8:5];
		tg   = a[31:9];
		miss = 1'b1;
		way  = '0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (m_valid[idx][w] && m_tag[idx][w] == tg) begin
				miss = 1'b0;
				way  = way_t'(w);
			end
		end
		if (miss) begin
			found = 1'b0;
			for (int w = 0; w < NUM_WAYS; w++) begin
				if (!found && !m_valid[idx][w]) begin   // lowest empty way
					way   = way_t'(w);
					found = 1'b1;
				end
			end
			if (!found)
				way = m_plru[idx][0] ? {1'b1, m_plru[idx][2]} : {1'b0, m_plru[idx][1]};
			m_valid[idx][way] = 1'b1;
			m_tag[idx][way]   = tg;
		end
		m_plru[idx][0] = ~way[1];   // root to the other pair
		if (way[1])
			m_plru[idx][2] = ~way[0];
		else
			m_plru[idx][1] = ~way[0];
	endtask

	task automatic wait_ready(output bit ok);
		int cnt;
		cnt = 0;
		while (!ready && cnt < READY_LIMIT) begin
			@(negedge clk);
			cnt++;
		end
		ok = ready;
	endtask

	task automatic apply_reset();
		@(negedge clk);   // last response already taken by the checker
		mid_rst_n = 1'b0;
		repeat (2) @(negedge clk);
		mid_rst_n = 1'b1;
		model_clear();
	endtask

	// bus memory, eight words per request with random gaps
	initial begin
		addr_t       line;
		int unsigned gap;
		bus_valid = 1'b0;
		bus_data  = '0;
		forever begin
			@(negedge clk);
			if (bus_req) begin
				line = bus_addr;
				for (int k = 0; k < LINE_WORDS; k++) begin
					gap = $urandom_range(3, 0);
					repeat (gap) @(negedge clk);
					bus_valid = 1'b1;
					bus_data  = mem_word(line + addr_t'(4 * k));
					@(negedge clk);
					bus_valid = 1'b0;
				end
			end
		end
	end

	initial begin
		int unsigned seed_ret;
		int          cnt;
		bit          ok;
		bit          hung;
		bit          miss_m;
		req       = 1'b0;
		addr      = '0;
		mid_rst_n = 1'b1;
		exp_miss  = 1'b0;
		row       = 0;
		hung      = 1'b0;
		cnt       = 0;
		seed_ret  = $urandom(SEED);
		build_table();
		model_clear();
		while (!rst_n && cnt < 10) begin   // power-on reset
			@(negedge clk);
			cnt++;
		end
		for (int r = 0; r < NROWS; r++) begin
			wait_ready(ok);   // previous response out first
			if (!ok) begin
				hung = 1'b1;
				break;
			end
			if (tab[r][33])
				apply_reset();
			model_access(tab[r][31:0], miss_m);   // model runs on every row
			req      = 1'b1;
			addr     = tab[r][31:0];
			exp_miss = tab_model[r] ? miss_m : tab[r][32];
			row      = r;
			@(negedge clk);
			req = 1'b0;
		end
		if (!hung) begin
			wait_ready(ok);   // last response
			hung = !ok;
		end
		@(posedge clk);
		if (hung)
			$display("cache did not return to ready in time");
		$display("rows %0d, ok %0d, bad %0d", NROWS, ok_cnt, bad_cnt);
		if (!hung && bad_cnt == 0 && ok_cnt == NROWS)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
hdl/icache_pkg.sv
hdl/icache_tag_store.sv
hdl/icache_data_store.sv
hdl/icache_fetch_ctrl.sv
hdl/icache_top.sv
tb/tb_clock_gen.sv
tb/icache_checker.sv
tb/icache_tb.sv

// ==== Makefile ====
# Verilator build and run of the icache testbench

VERILATOR ?= verilator
TOP       ?= icache_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test passed
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
